// File: Makefile
TOP = coinc_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir

.PHONY: sim clean

// File: list.f
verilog/coinc_pkg.sv
verilog/hit_frontend.sv
verilog/hit_aligner.sv
verilog/window_timer.sv
verilog/coinc_sequencer.sv
verilog/seed_logic.sv
verilog/trigger_prescaler.sv
verilog/coinc_top.sv
tb/coinc_props.sv
tb/coinc_tb.sv

// File: tb/coinc_props.sv
`timescale 1ns/100ps

module coinc_props (
	input logic                clk_in,
	input logic                rst_in,
	input logic                fire,
	input logic                busy,
	input logic                trig,
	input coinc_pkg::grp_vec_t grp_res,
	input coinc_pkg::grp_vec_t tag
);

	// trig is a strobe, never two cycles wide
	a_trig_single: assert property (@(posedge clk_in) disable iff (rst_in)
		trig |=> !trig)
		else $error("trig high on two consecutive cycles");

	a_busy_veto: assert property (@(posedge clk_in) disable iff (rst_in)
		(fire && busy) |=> !trig)  // tracker busy during fire
		else $error("trig rose although busy was high in fire");

	// prescaling only removes bits from the group result
	a_tag_subset: assert property (@(posedge clk_in) disable iff (rst_in)
		fire |=> ((tag & ~grp_res) == '0))
		else $error("tag has a bit that grp_res lacks");

endmodule

bind coinc_top coinc_props u_props (.clk_in, .rst_in, .fire, .busy, .trig, .grp_res, .tag);

// File: tb/coinc_tb.sv
`timescale 1ns/100ps

module coinc_tb;
	import coinc_pkg::*;

	typedef logic [NUM_GRP-1:0][15:0] cnt_t;  // same shape as the dut counters

	localparam int N_EVENTS = 74;  // 24 + 40 + 1 + 6 + 3
	localparam int LIMIT    = 400 * N_EVENTS + 200;

	logic       clk_in;
	logic       rst_in;
	hit_pins_t  pins;
	coinc_cfg_t cfg;
	logic       trig;
	grp_vec_t   tag;
	logic       logic_match;
	cnt_t       cnt;

	integer   seed = 32'h5a06;
	int       n_checks = 0;
	int       n_errors = 0;
	int       test_err0 = 0;  // errors at the start of the running test
	int       trig_total = 0;  // trig pulses since time zero
	logic     busy_on;
	cnt_t     m_cnt;  // model state after the last event
	grp_vec_t m_tag;
	grp_vec_t m_res;
	logic     exp_trig;
	logic     lm_fire = 1'b0;  // logic_match seen in the fire cycle
	hit_vec_t prev_aln = '0;
	hit_vec_t first_aln = '0;  // aligned pattern at the start of an event
	event     ev_done;

	coinc_top #(.ALIGN_DEPTH(256), .CNT_W(16)) dut (
		.clk_in, .rst_in, .pins, .cfg, .trig, .tag, .logic_match, .cnt
	);

	initial begin
		clk_in = 1'b0;
		forever #2 clk_in = ~clk_in;
	end

	// expected outcome of one event, straight from the trigger rules
	function automatic void model_event(input hit_vec_t h, input coinc_cfg_t c,
			input cnt_t cnt_in, input grp_vec_t tag_in, input logic busy_in,
			output grp_vec_t res, output grp_vec_t tag_out, output logic trig_out,
			output cnt_t cnt_out);
		int       mip_k [8] = '{0, 1, 2, 5, 6, 7, 8, 9};
		int       ubs_k [8] = '{0, 5, 6, 7, 8, 9, 10, 11};
		int       k [NUM_GRP];
		grp_vec_t en;
		logic     top, sec, csi, cal13;
		res = '0;
		tag_out = tag_in;
		trig_out = 1'b0;
		cnt_out = cnt_in;
		if (h == '0)
			return;  // no window opens, dut keeps tag and counts
		top = h[CH_ACD_TOP];
		sec = h[CH_ACD_SEC];
		csi = h[CH_CSI];
		cal13 = h[CH_CAL1] | h[CH_CAL3];
		case (c.grp_sel[GRP_MIP1])
			2'd0: res[GRP_MIP1] = top & csi;
			2'd1: res[GRP_MIP1] = top & sec & csi & (h[CH_CAL2] | h[CH_CAL4]);
			2'd2: res[GRP_MIP1] = top;
			default: res[GRP_MIP1] = top | sec | csi | h[CH_CAL2];
		endcase
		res[GRP_MIP2] = (c.grp_sel[GRP_MIP2] == 2'd1) ? h[CH_CAL2] & h[CH_CAL4]
			: (c.grp_sel[GRP_MIP2] == 2'd2) && top && csi;
		res[GRP_GM1] = (c.grp_sel[GRP_GM1] == 2'd1) ? !top && !sec && csi && cal13
			: (c.grp_sel[GRP_GM1] == 2'd2) && top && csi && h[CH_CAL2];
		res[GRP_GM2] = (c.grp_sel[GRP_GM2] == 2'd1) && !(top && sec) && csi && cal13;
		res[GRP_UBS] = (c.grp_sel[GRP_UBS] == 2'd1) && cal13;
		k[GRP_MIP1] = mip_k[c.mip1_div];
		k[GRP_MIP2] = mip_k[c.mip2_div];
		k[GRP_GM1] = 0;  // gamma never thinned
		k[GRP_GM2] = 0;
		k[GRP_UBS] = ubs_k[c.ubs_div];
		for (int g = 0; g < NUM_GRP; g++) begin
			en[g] = (cnt_in[g] % (1 << k[g])) == 0;  // one in 2^k passes
			if (res[g])
				cnt_out[g] = cnt_in[g] + 1'b1;
		end
		tag_out = en & res;
		trig_out = |(tag_out & c.grp_oe) && !busy_in;
	endfunction

	function automatic coinc_cfg_t base_cfg();
		coinc_cfg_t c;
		c = '0;
		c.hit_ab_sel = 8'b1010_0101;  // mix of a and b pins
		c.acd_csi_diff = 8'd3;
		for (int i = 0; i < NUM_CH; i++)
			c.ch_align[i] = 8'(2 + i % 5);  // 2 .. 6
		c.seed_win = 8'd30;
		c.hold_win = 8'd5;
		c.grp_oe = '1;
		return c;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic do_reset();
		@(negedge clk_in);
		rst_in = 1'b1;
		repeat (3) @(negedge clk_in);
		rst_in = 1'b0;
		m_cnt = '0;
		m_tag = '0;
	endtask

	// late channels start 3 cycles after early ones, each low for 12 cycles
	task automatic run_event(input hit_vec_t early, input hit_vec_t late, input logic wrong_pin);
		hit_vec_t lo;
		hit_vec_t on_b;  // channels driven on pin b
		int       quiet;
		on_b = cfg.hit_ab_sel ^ {NUM_CH{wrong_pin}};
		for (int c = 0; c < 16; c++) begin
			@(negedge clk_in);
			lo = (c < 12 ? early : '0) | ((c >= 3 && c < 15) ? late : '0);
			pins.hit_a_n = ~(lo & ~on_b);
			pins.hit_b_n = ~(lo & on_b);
		end
		quiet = 0;
		// pipeline drains well within 20 cycles, then wait for idle
		while (quiet < 20 || dut.u_seq.state != IDLE) begin
			@(negedge clk_in);
			quiet++;
		end
	endtask

	task automatic do_event(input hit_vec_t early, input hit_vec_t late, input logic wrong_pin);
		hit_vec_t eff;  // channels that really reach the seed
		eff = wrong_pin ? '0 : (early | late) & ~cfg.hit_mask;
		model_event(eff, cfg, m_cnt, m_tag, busy_on, m_res, m_tag, exp_trig, m_cnt);
		lm_fire = 1'b0;
		run_event(early, late, wrong_pin);
		-> ev_done;
		@(negedge clk_in);
	endtask

	task automatic end_test(input string name);
		$display("test %-16s %s (%0d errors)", name,
			(n_errors == test_err0) ? "ok" : "fail", n_errors - test_err0);
		test_err0 = n_errors;
	endtask

	always @(negedge clk_in) begin
		if (trig)
			trig_total++;
		if (dut.fire)
			lm_fire = logic_match;  // settled from the final seed in eval
		if (dut.hit_aln != '0 && prev_aln == '0)
			first_aln = dut.hit_aln;  // first cycle with any aligned hit
		prev_aln = dut.hit_aln;
	end

	// comparison after every event
	initial begin
		int last_trig;
		last_trig = 0;
		forever begin
			@(ev_done);
			check("trig pulses", trig_total - last_trig, exp_trig);
			last_trig = trig_total;
			check("tag", tag, m_tag);
			check("logic_match", lm_fire, |(m_res & cfg.grp_oe));
			for (int g = 0; g < NUM_GRP; g++)
				check($sformatf("cnt[%0d]", g), cnt[g], m_cnt[g]);
		end
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk_in);
			cycles++;
		end
		$display("timeout: the events did not finish within %0d cycles", LIMIT);
		$display("TESTS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] rnd;
		int          t0;
		pins = '1;  // every pin idle high
		rst_in = 1'b1;
		busy_on = 1'b0;
		cfg = base_cfg();
		cfg.grp_sel[GRP_MIP1] = 2'b11;  // every channel except side and cal4 triggers
		cfg.grp_sel[GRP_MIP2] = 2'b01;
		cfg.grp_sel[GRP_UBS] = 2'b01;
		do_reset();
		for (int i = 0; i < NUM_CH; i++) begin
			do_event(hit_vec_t'(1 << i), '0, 1'b1);  // unselected pin
			cfg.hit_mask = hit_vec_t'(1 << i);
			do_event(hit_vec_t'(1 << i), '0, 1'b0);
			cfg.hit_mask = '0;
			do_event(hit_vec_t'(1 << i), '0, 1'b0);
		end
		end_test("ab_select_mask");
		cfg = base_cfg();
		do_reset();
		for (int n = 0; n < 40; n++) begin
			rnd = $random(seed);
			cfg.grp_sel = rnd[9:0];
			do_event(rnd[17:10], '0, 1'b0);
		end
		end_test("logic_groups");
		cfg = base_cfg();
		cfg.ch_align[CH_ACD_TOP] = 8'd4;  // plus 3 of acd_csi_diff
		cfg.ch_align[CH_CSI] = 8'd4;
		do_reset();
		t0 = trig_total;
		do_event(8'h80, 8'h10, 1'b0);  // csi 3 cycles behind top
		check("aligned hits", first_aln, 8'h90);
		check("mip1 trig", trig_total - t0, 1);
		end_test("alignment");
		cfg = base_cfg();
		cfg.mip1_div = 3'd1;
		do_reset();
		t0 = trig_total;
		for (int n = 0; n < 6; n++)
			do_event(8'h90, '0, 1'b0);
		check("prescaled trig pulses", trig_total - t0, 3);
		check("mip1 count", cnt[GRP_MIP1], 6);
		end_test("prescale");
		cfg = base_cfg();
		do_reset();
		busy_on = 1'b1;
		pins.busy_a_n = 2'b10;  // tracker 0 busy
		do_event(8'h90, '0, 1'b0);
		do_event(8'h90, '0, 1'b0);
		busy_on = 1'b0;
		pins.busy_a_n = 2'b11;
		cfg.grp_oe = 5'b11110;  // mip1 output off
		do_event(8'h90, '0, 1'b0);
		check("tag with oe off", tag[GRP_MIP1], 1'b1);
		end_test("busy_and_oe");
		$display("%0d checks, %0d errors", n_checks, n_errors);
		if (n_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// File: verilog/coinc_pkg.sv
package coinc_pkg;

	localparam int NUM_CH  = 8;  // hit channels
	localparam int NUM_GRP = 5;  // coincidence logic groups

	// channel bit positions in every hit vector
	localparam int CH_ACD_TOP = 7;
	localparam int CH_ACD_SEC = 6;
	localparam int CH_ACD_SID = 5;
	localparam int CH_CSI     = 4;
	localparam int CH_CAL1    = 3;
	localparam int CH_CAL2    = 2;
	localparam int CH_CAL3    = 1;
	localparam int CH_CAL4    = 0;

	localparam int GRP_MIP1 = 0;
	localparam int GRP_MIP2 = 1;
	localparam int GRP_GM1  = 2;
	localparam int GRP_GM2  = 3;
	localparam int GRP_UBS  = 4;  // unbiased

	typedef logic [NUM_CH-1:0]  hit_vec_t;  // active high once selected
	typedef logic [NUM_GRP-1:0] grp_vec_t;

	typedef struct packed {
		logic [NUM_CH-1:0] hit_a_n;   // redundant pin pair, active low
		logic [NUM_CH-1:0] hit_b_n;
		logic [1:0]        busy_a_n;  // two si tracker busy lines
		logic [1:0]        busy_b_n;
	} hit_pins_t;

	// all fields together need 132 bits, so the word is padded to 136
	typedef struct packed {
		logic [3:0]               pad;
		logic [NUM_CH-1:0]        hit_ab_sel;    // 1 picks pin b
		logic [NUM_CH-1:0]        hit_mask;      // 1 kills the channel
		logic [1:0]               busy_ab_sel;
		logic [1:0]               busy_mask;
		logic [7:0]               acd_csi_diff;  // acd hits lead csi by this much
		logic [NUM_CH-1:0][7:0]   ch_align;      // indexed by channel
		logic [7:0]               seed_win;
		logic [7:0]               hold_win;
		logic [NUM_GRP-1:0][1:0]  grp_sel;
		grp_vec_t                 grp_oe;
		logic [2:0]               mip1_div;
		logic [2:0]               mip2_div;
		logic [2:0]               ubs_div;
	} coinc_cfg_t;

	// low count bits that must be zero per divider code, entry 0 on the right
	localparam logic [7:0][3:0] MIP_DIV_BITS = {4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd2, 4'd1, 4'd0};
	localparam logic [7:0][3:0] UBS_DIV_BITS = {4'd11, 4'd10, 4'd9, 4'd8, 4'd7, 4'd6, 4'd5, 4'd0};

	typedef enum logic [2:0] {IDLE, SEED, EVAL, FIRE, HOLD, RELEASE} seq_state_t;

endpackage

// File: verilog/coinc_sequencer.sv
`timescale 1ns/100ps

module coinc_sequencer (
	input  logic                  clk_in,
	input  logic                  rst_in,
	input  logic                  hit_start,
	input  logic                  timer_done,
	input  coinc_pkg::coinc_cfg_t cfg,
	output logic                  timer_load,
	output logic                  seed_clr,
	output logic                  seed_en,
	output logic                  eval_en,
	output logic                  fire,
	output logic [7:0]            timer_len
);
	import coinc_pkg::*;

	seq_state_t state;
	seq_state_t state_nxt;

	always_ff @(posedge clk_in) begin
		if (rst_in)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		case (state)
			IDLE: begin
				if (hit_start)
					state_nxt = SEED;  // first aligned hit opens the window
			end
			SEED: begin
				if (timer_done)
					state_nxt = EVAL;
			end
			EVAL:
				state_nxt = FIRE;
			FIRE:
				state_nxt = HOLD;
			HOLD: begin
				if (timer_done)
					state_nxt = RELEASE;
			end
			RELEASE: begin
				// hits must drop before a new window may open
				if (!hit_start)
					state_nxt = IDLE;
			end
			default:
				state_nxt = IDLE;
		endcase
	end

	// the one timer serves the seed window and then the hold window
	assign timer_load = (state == IDLE && hit_start) || (state == FIRE);
	assign timer_len  = (state == FIRE) ? cfg.hold_win : cfg.seed_win;

	// opening hit is latched as well, so a short pulse is not lost
	assign seed_en  = (state == SEED) || (state == IDLE && hit_start);
	assign eval_en  = (state == EVAL);
	assign fire     = (state == FIRE);
	assign seed_clr = (state == RELEASE);

endmodule

// File: verilog/coinc_top.sv
`timescale 1ns/100ps

module coinc_top #(
	parameter int ALIGN_DEPTH = 256,
	parameter int CNT_W       = 16
) (
	input  logic                                     clk_in,
	input  logic                                     rst_in,
	input  coinc_pkg::hit_pins_t                     pins,
	input  coinc_pkg::coinc_cfg_t                    cfg,      // static during a run
	output logic                                     trig,
	output coinc_pkg::grp_vec_t                      tag,
	output logic                                     logic_match,
	output logic [coinc_pkg::NUM_GRP-1:0][CNT_W-1:0] cnt       // mip1 at index 0
);
	import coinc_pkg::*;

	hit_vec_t               hit_sync;
	hit_vec_t               hit_aln;
	logic                   busy;
	logic [NUM_CH-1:0][7:0] ch_delay;
	logic                   timer_load, timer_done;
	logic [7:0]             timer_len;
	logic                   seed_clr, seed_en, eval_en, fire;
	grp_vec_t               grp_res;

	hit_frontend u_front (.clk_in, .rst_in, .pins, .cfg, .hit_sync, .busy, .ch_delay);

	// one delay line per channel lines fast and slow detectors up
	for (genvar i = 0; i < NUM_CH; i++) begin : g_aln
		hit_aligner #(.ALIGN_DEPTH(ALIGN_DEPTH)) u_aln (
			.clk_in,
			.rst_in,
			.hit     (hit_sync[i]),
			.delay   (ch_delay[i]),
			.hit_aln (hit_aln[i])
		);
	end

	window_timer u_timer (.clk_in, .rst_in, .timer_load, .timer_len, .timer_done);

	coinc_sequencer u_seq (
		.clk_in, .rst_in,
		.hit_start (|hit_aln),  // any aligned hit starts an event
		.timer_done, .cfg,
		.timer_load, .seed_clr, .seed_en, .eval_en, .fire, .timer_len
	);

	seed_logic u_seed (
		.clk_in, .rst_in, .seed_clr, .seed_en, .eval_en,
		.hit_aln, .cfg, .grp_res, .logic_match
	);

	trigger_prescaler #(.CNT_W(CNT_W)) u_presc (
		.clk_in, .rst_in, .fire, .busy, .grp_res, .cfg, .trig, .tag, .cnt
	);

endmodule

// File: verilog/hit_aligner.sv
`timescale 1ns/100ps

module hit_aligner #(
	parameter int ALIGN_DEPTH = 256  // power of two, 16 or more
) (
	input  logic       clk_in,
	input  logic       rst_in,
	input  logic       hit,
	input  logic [7:0] delay,    // 1 .. ALIGN_DEPTH-1
	output logic       hit_aln
);

	localparam int PTR_W = $clog2(ALIGN_DEPTH);

	logic [ALIGN_DEPTH-1:0] ring;    // one bit per slot
	logic [PTR_W-1:0]       wr_ptr;
	logic [PTR_W-1:0]       rd_ptr;

	// read slot trails the write slot by delay, wraps on its own
	assign rd_ptr = wr_ptr - PTR_W'(delay);

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			ring    <= '0;
			wr_ptr  <= '0;
			hit_aln <= 1'b0;
		end else begin
			ring[wr_ptr] <= hit;
			hit_aln      <= ring[rd_ptr];  // total latency delay+1
			wr_ptr       <= wr_ptr + 1'b1;
		end
	end

endmodule

// File: verilog/hit_frontend.sv
`timescale 1ns/100ps

module hit_frontend (
	input  logic                               clk_in,
	input  logic                               rst_in,
	input  coinc_pkg::hit_pins_t               pins,
	input  coinc_pkg::coinc_cfg_t              cfg,
	output coinc_pkg::hit_vec_t                hit_sync,
	output logic                               busy,
	output logic [coinc_pkg::NUM_CH-1:0][7:0]  ch_delay
);
	import coinc_pkg::*;

	hit_vec_t   hit_sel;     // pins inverted, a/b picked, masked
	hit_vec_t   hit_s1;      // first sync stage
	logic [1:0] busy_sel;
	logic [1:0] busy_s1;
	logic [1:0] busy_s2;

	// per bit a/b mux then mask
	assign hit_sel = ~cfg.hit_mask &
		((~cfg.hit_ab_sel & ~pins.hit_a_n) | (cfg.hit_ab_sel & ~pins.hit_b_n));
	assign busy_sel = ~cfg.busy_mask &
		((~cfg.busy_ab_sel & ~pins.busy_a_n) | (cfg.busy_ab_sel & ~pins.busy_b_n));

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			hit_s1   <= '0;
			hit_sync <= '0;
			busy_s1  <= '0;
			busy_s2  <= '0;
		end else begin
			hit_s1   <= hit_sel;   // pins are asynchronous here
			hit_sync <= hit_s1;
			busy_s1  <= busy_sel;
			busy_s2  <= busy_s1;
		end
	end

	assign busy = |busy_s2;  // either tracker busy vetoes

	// acd hits arrive well before csi, so acd channels carry the extra offset
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (i == CH_ACD_TOP || i == CH_ACD_SEC || i == CH_ACD_SID)
				ch_delay[i] = cfg.ch_align[i] + cfg.acd_csi_diff;
			else
				ch_delay[i] = cfg.ch_align[i];
		end
	end

endmodule

// File: verilog/seed_logic.sv
`timescale 1ns/100ps

module seed_logic (
	input  logic                  clk_in,
	input  logic                  rst_in,
	input  logic                  seed_clr,
	input  logic                  seed_en,
	input  logic                  eval_en,
	input  coinc_pkg::hit_vec_t   hit_aln,
	input  coinc_pkg::coinc_cfg_t cfg,
	output coinc_pkg::grp_vec_t   grp_res,
	output logic                  logic_match
);
	import coinc_pkg::*;

	hit_vec_t seed;      // sticky hit pattern of the window
	grp_vec_t grp_live;  // group results from the current seed
	logic     top, sec, csi, cal1, cal2, cal3, cal4;

	always_ff @(posedge clk_in) begin
		if (rst_in || seed_clr)
			seed <= '0;
		else if (seed_en)
			seed <= seed | hit_aln;
	end

	assign top  = seed[CH_ACD_TOP];
	assign sec  = seed[CH_ACD_SEC];
	assign csi  = seed[CH_CSI];
	assign cal1 = seed[CH_CAL1];
	assign cal2 = seed[CH_CAL2];
	assign cal3 = seed[CH_CAL3];
	assign cal4 = seed[CH_CAL4];

	always_comb begin
		grp_live = '0;  // unlisted selects give no match
		case (cfg.grp_sel[GRP_MIP1])
			2'b00: grp_live[GRP_MIP1] = top & csi;
			2'b01: grp_live[GRP_MIP1] = top & sec & csi & (cal2 | cal4);
			2'b10: grp_live[GRP_MIP1] = top;
			2'b11: grp_live[GRP_MIP1] = top | sec | csi | cal2;  // loose, for tests
			default: grp_live[GRP_MIP1] = 1'b0;
		endcase
		case (cfg.grp_sel[GRP_MIP2])
			2'b01: grp_live[GRP_MIP2] = cal2 & cal4;
			2'b10: grp_live[GRP_MIP2] = top & csi;
			default: grp_live[GRP_MIP2] = 1'b0;
		endcase
		case (cfg.grp_sel[GRP_GM1])
			2'b01: grp_live[GRP_GM1] = ~top & ~sec & csi & (cal1 | cal3);  // acd quiet
			2'b10: grp_live[GRP_GM1] = top & csi & cal2;
			default: grp_live[GRP_GM1] = 1'b0;
		endcase
		if (cfg.grp_sel[GRP_GM2] == 2'b01)
			grp_live[GRP_GM2] = (~top | ~sec) & csi & (cal1 | cal3);
		if (cfg.grp_sel[GRP_UBS] == 2'b01)
			grp_live[GRP_UBS] = cal1 | cal3;
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			grp_res     <= '0;
			logic_match <= 1'b0;
		end else begin
			if (eval_en)
				grp_res <= grp_live;  // frozen until the next event
			logic_match <= |(grp_live & cfg.grp_oe);  // free running, debug aid
		end
	end

endmodule

// File: verilog/trigger_prescaler.sv
`timescale 1ns/100ps

module trigger_prescaler #(
	parameter int CNT_W = 16
) (
	input  logic                                   clk_in,
	input  logic                                   rst_in,
	input  logic                                   fire,
	input  logic                                   busy,
	input  coinc_pkg::grp_vec_t                    grp_res,
	input  coinc_pkg::coinc_cfg_t                  cfg,
	output logic                                   trig,
	output coinc_pkg::grp_vec_t                    tag,
	output logic [coinc_pkg::NUM_GRP-1:0][CNT_W-1:0] cnt
);
	import coinc_pkg::*;

	logic [NUM_GRP-1:0][3:0]       div_bits;  // low bits to test per group
	logic [NUM_GRP-1:0][CNT_W-1:0] low_mask;
	grp_vec_t                      presc_en;

	// gamma groups are never thinned, k=0 leaves them always enabled
	assign div_bits[GRP_MIP1] = MIP_DIV_BITS[cfg.mip1_div];
	assign div_bits[GRP_MIP2] = MIP_DIV_BITS[cfg.mip2_div];
	assign div_bits[GRP_GM1]  = 4'd0;
	assign div_bits[GRP_GM2]  = 4'd0;
	assign div_bits[GRP_UBS]  = UBS_DIV_BITS[cfg.ubs_div];

	always_comb begin
		for (int g = 0; g < NUM_GRP; g++) begin
			low_mask[g] = (CNT_W'(1) << div_bits[g]) - CNT_W'(1);
			presc_en[g] = (cnt[g] & low_mask[g]) == '0;  // every 2^k-th event
		end
	end

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			trig <= 1'b0;
			tag  <= '0;
			cnt  <= '0;
		end else begin
			// one cycle pulse right after fire, tracker busy vetoes
			trig <= fire && !busy && |(presc_en & grp_res & cfg.grp_oe);
			if (fire) begin
				tag <= presc_en & grp_res;  // before oe masking
				for (int g = 0; g < NUM_GRP; g++) begin
					if (grp_res[g])
						cnt[g] <= cnt[g] + 1'b1;  // counts raw matches
				end
			end
		end
	end

endmodule

// File: verilog/window_timer.sv
`timescale 1ns/100ps

module window_timer (
	input  logic       clk_in,
	input  logic       rst_in,
	input  logic       timer_load,
	input  logic [7:0] timer_len,
	output logic       timer_done
);

	logic [7:0] cnt;      // cycles left after this one
	logic       running;

	always_ff @(posedge clk_in) begin
		if (rst_in) begin
			cnt     <= '0;
			running <= 1'b0;
		end else if (timer_load) begin
			cnt     <= timer_len;  // counts len+1 cycles from next
			running <= 1'b1;
		end else if (running) begin
			if (cnt == 8'd0)
				running <= 1'b0;
			else
				cnt <= cnt - 1'b1;
		end
	end

	// single cycle pulse in the last counted cycle
	assign timer_done = running && (cnt == 8'd0);

endmodule
